//--- verilog/link_params.svh
`ifndef LINK_PARAMS_SVH
`define LINK_PARAMS_SVH

// Frame layout: start, data LSB first, parity, stop

`define LINK_DATA_BITS   8      // Payload bits per frame

`define LINK_FRAME_BITS  11     // Start + data + parity + stop

// Set to 1'b1 for odd parity
`define LINK_ODD_PARITY  1'b0   // Required XOR of data and parity bit

`define LINK_COUNT_BITS  16     // Width of status counters

`define LINK_IDLE_LEVEL  1'b1   // Line level between frames, also the stop bit

`endif

//--- verilog/link_pkg.sv
package link_pkg;

    `include "link_params.svh"

    typedef logic [`LINK_DATA_BITS-1:0]  data_t;    // One payload byte
    typedef logic [`LINK_COUNT_BITS-1:0] count_t;   // Frame and error counters
    typedef logic [3:0]                  bit_idx_t; // Bit position inside a frame

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE,                            // Waiting for start bit
        RX_DATA,                            // Data and parity bits
        RX_STOP                             // Sampling stop bit
    } rx_state_t;

    // Transmitter FSM
    typedef enum logic {
        TX_IDLE,                            // Line held at idle level
        TX_SHIFT                            // Frame going out
    } tx_state_t;

endpackage

//--- verilog/rx_frame_if.sv
`timescale 1ns/1ps

// One decoded frame, receiver to status block
interface rx_frame_if;

    link_pkg::data_t data;                  // Received payload
    logic            valid;                 // One-cycle strobe per frame
    logic            parity_error;          // Valid with strobe only
    logic            stop_error;            // Valid with strobe only

    modport source (
        output data,
        output valid,
        output parity_error,
        output stop_error
    );

    // No handshake, sink takes frame in the valid cycle
    modport sink (
        input  data,
        input  valid,
        input  parity_error,
        input  stop_error
    );

endinterface

//--- verilog/uart_rx.sv
`timescale 1ns/1ps
`include "link_params.svh"

module uart_rx (
    input  logic       baud_clk,            // One edge per bit time
    input  logic       reset,               // Sync, active high
    input  logic       rx_line,             // Serial input
    rx_frame_if.source frame                // Decoded frame out
);

    link_pkg::rx_state_t      state;        // Receiver FSM
    link_pkg::bit_idx_t       bit_cnt;      // Bits stored in this frame
    logic [`LINK_DATA_BITS:0] shift_reg;    // Parity in MSB, data below
    logic                     parity_bad;   // Parity rule violated
    logic                     valid_q;      // Frame strobe
    logic                     parity_err_q;
    logic                     stop_err_q;

    // XOR over data and parity must equal the configured parity mode
    assign parity_bad = ((^shift_reg) != `LINK_ODD_PARITY);

    // Data bits sit in the low part once all nine are shifted in
    assign frame.data         = shift_reg[`LINK_DATA_BITS-1:0];
    assign frame.valid        = valid_q;
    assign frame.parity_error = parity_err_q;
    assign frame.stop_error   = stop_err_q;

    // Control path
    always_ff @(posedge baud_clk) begin
        if (reset) begin
            state        <= link_pkg::RX_IDLE;
            bit_cnt      <= '0;
            valid_q      <= 1'b0;
            parity_err_q <= 1'b0;
            stop_err_q   <= 1'b0;
        end else begin
            valid_q      <= 1'b0;           // Strobes last one cycle
            parity_err_q <= 1'b0;
            stop_err_q   <= 1'b0;
            case (state)
                link_pkg::RX_IDLE: begin
                    if (rx_line != `LINK_IDLE_LEVEL) begin  // Start bit seen
                        state   <= link_pkg::RX_DATA;
                        bit_cnt <= '0;
                    end
                end

                link_pkg::RX_DATA: begin
                    bit_cnt <= bit_cnt + link_pkg::bit_idx_t'(1);
                    // Last of data plus parity
                    if (bit_cnt == link_pkg::bit_idx_t'(`LINK_DATA_BITS)) begin
                        state <= link_pkg::RX_STOP;
                    end
                end

                link_pkg::RX_STOP: begin
                    valid_q      <= 1'b1;       // Errored frames strobe too
                    parity_err_q <= parity_bad;
                    stop_err_q   <= (rx_line != `LINK_IDLE_LEVEL);
                    state        <= link_pkg::RX_IDLE;  // Ready for next start bit
                end

                default: begin
                    state <= link_pkg::RX_IDLE;
                end
            endcase
        end
    end

    // Payload shifter, LSB arrives first
    always_ff @(posedge baud_clk) begin
        if (state == link_pkg::RX_DATA) begin
            shift_reg <= {rx_line, shift_reg[`LINK_DATA_BITS:1]};
        end
    end

endmodule

//--- verilog/uart_tx.sv
`timescale 1ns/1ps
`include "link_params.svh"

module uart_tx (
    input  logic            baud_clk,       // One edge per bit time
    input  logic            reset,          // Sync, active high
    input  link_pkg::data_t tx_data,        // Byte to send
    input  logic            tx_start,       // Start strobe
    output logic            tx_line,        // Serial output
    output logic            tx_busy         // High while a frame is out
);

    link_pkg::tx_state_t         state;     // Transmitter FSM
    link_pkg::bit_idx_t          bit_cnt;   // Bit currently on the line
    logic [`LINK_FRAME_BITS-1:0] frame_sr;  // Stop, parity, data, start
    logic                        parity_bit;
    logic                        start_ok;  // Start accepted this cycle

    // Makes XOR of data and parity equal the parity mode
    assign parity_bit = (^tx_data) ^ `LINK_ODD_PARITY;

    assign start_ok = (state == link_pkg::TX_IDLE) && tx_start;  // Ignored while busy
    assign tx_busy  = (state == link_pkg::TX_SHIFT);

    // Control path, line output registered
    always_ff @(posedge baud_clk) begin
        if (reset) begin
            state   <= link_pkg::TX_IDLE;
            bit_cnt <= '0;
            tx_line <= `LINK_IDLE_LEVEL;
        end else begin
            case (state)
                link_pkg::TX_IDLE: begin
                    tx_line <= `LINK_IDLE_LEVEL;
                    if (tx_start) begin
                        state   <= link_pkg::TX_SHIFT;
                        bit_cnt <= '0;
                        tx_line <= ~`LINK_IDLE_LEVEL;   // Start bit
                    end
                end

                link_pkg::TX_SHIFT: begin
                    // Stop bit has had its cycle
                    if (bit_cnt == link_pkg::bit_idx_t'(`LINK_FRAME_BITS - 1)) begin
                        state   <= link_pkg::TX_IDLE;
                        tx_line <= `LINK_IDLE_LEVEL;
                    end else begin
                        bit_cnt <= bit_cnt + link_pkg::bit_idx_t'(1);
                        tx_line <= frame_sr[1];         // Next bit before shift
                    end
                end

                default: begin
                    state   <= link_pkg::TX_IDLE;
                    tx_line <= `LINK_IDLE_LEVEL;
                end
            endcase
        end
    end

    // Frame register, loaded once per accepted start
    always_ff @(posedge baud_clk) begin
        if (start_ok) begin
            frame_sr <= {`LINK_IDLE_LEVEL, parity_bit, tx_data, ~`LINK_IDLE_LEVEL};
        end else if (state == link_pkg::TX_SHIFT) begin
            frame_sr <= {`LINK_IDLE_LEVEL, frame_sr[`LINK_FRAME_BITS-1:1]};  // Fill with idle
        end
    end

endmodule

//--- verilog/rx_status.sv
`timescale 1ns/1ps

module rx_status (
    input  logic             baud_clk,      // Bit clock
    input  logic             reset,         // Synchronous active high
    rx_frame_if.sink         frame,         // From receiver
    output link_pkg::count_t frame_count,   // All received frames
    output link_pkg::count_t error_count,   // Frames with any error
    output link_pkg::data_t  last_data      // Last error-free byte
);

    logic frame_bad;                        // Parity or stop failed

    assign frame_bad = frame.parity_error | frame.stop_error;

    // Frame counter wraps at full scale
    always_ff @(posedge baud_clk) begin
        if (reset) begin
            frame_count <= '0;
        end else if (frame.valid) begin
            frame_count <= frame_count + link_pkg::count_t'(1);
        end
    end

    // Error counter wraps at full scale
    always_ff @(posedge baud_clk) begin
        if (reset) begin
            error_count <= '0;
        end else if (frame.valid && frame_bad) begin
            error_count <= error_count + link_pkg::count_t'(1);
        end
    end

    // Bad frames leave the previous byte in place
    always_ff @(posedge baud_clk) begin
        if (reset) begin
            last_data <= '0;                // Zero until the first good frame
        end else if (frame.valid && !frame_bad) begin
            last_data <= frame.data;
        end
    end

endmodule

//--- verilog/serial_link_top.sv
`timescale 1ns/1ps

module serial_link_top (
    input  logic             baud_clk,          // One edge per bit time
    input  logic             reset,             // Sync, active high
    input  logic             rx_line,           // Serial in
    input  link_pkg::data_t  tx_data,           // Byte to send
    input  logic             tx_start,          // Send strobe
    output logic             tx_line,           // Serial out
    output logic             tx_busy,           // Transmitter busy
    output link_pkg::data_t  rx_data,           // Last good byte
    output logic             rx_valid,          // Frame strobe
    output logic             rx_parity_error,   // With rx_valid
    output logic             rx_stop_error,     // With rx_valid
    output link_pkg::count_t frame_count,
    output link_pkg::count_t error_count
);

    rx_frame_if frame_bus ();                   // Receiver to status

    uart_tx i_tx (
        .baud_clk (baud_clk),
        .reset    (reset),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_line  (tx_line),
        .tx_busy  (tx_busy)
    );

    uart_rx i_rx (
        .baud_clk (baud_clk),
        .reset    (reset),
        .rx_line  (rx_line),
        .frame    (frame_bus.source)
    );

    rx_status i_status (
        .baud_clk    (baud_clk),
        .reset       (reset),
        .frame       (frame_bus.sink),
        .frame_count (frame_count),
        .error_count (error_count),
        .last_data   (rx_data)
    );

    // Receiver strobes straight out
    assign rx_valid        = frame_bus.valid;
    assign rx_parity_error = frame_bus.parity_error;
    assign rx_stop_error   = frame_bus.stop_error;

endmodule

//--- bench/serial_link_tb.sv
`timescale 1ns/1ps
`include "link_params.svh"

module serial_link_tb;

    localparam int TIMEOUT_CYCLES = 20;     // Limit for every wait loop
    localparam int FRAME_CYCLES   = 11;     // Start to valid, also busy length
    localparam int OP_LOOP        = 0;
    localparam int OP_RAW         = 1;
    localparam int OP_BUSY        = 2;

    logic             baud_clk;
    logic             reset;
    logic             rx_line;
    link_pkg::data_t  tx_data;
    logic             tx_start;
    logic             tx_line;
    logic             tx_busy;
    link_pkg::data_t  rx_data;
    logic             rx_valid;
    logic             rx_parity_error;
    logic             rx_stop_error;
    link_pkg::count_t frame_count;
    link_pkg::count_t error_count;

    logic             loop_mode;            // Routes tx_line back to rx_line
    logic             raw_line;             // Line from the frame builder

    // Pattern table, one entry per line
    int               op_q[$];
    link_pkg::data_t  byte_q[$];
    int               pflip_q[$];
    int               sflip_q[$];
    int               exp_par_q[$];
    int               exp_stop_q[$];

    // Expected status block contents
    int               exp_frames;
    int               exp_errors;
    link_pkg::data_t  exp_last;

    int               err_cnt;
    int               pass_cnt;
    int               fail_cnt;
    int unsigned      rng_seed;

    assign rx_line = loop_mode ? tx_line : raw_line;    // Loopback mux

    serial_link_top i_dut (
        .baud_clk        (baud_clk),
        .reset           (reset),
        .rx_line         (rx_line),
        .tx_data         (tx_data),
        .tx_start        (tx_start),
        .tx_line         (tx_line),
        .tx_busy         (tx_busy),
        .rx_data         (rx_data),
        .rx_valid        (rx_valid),
        .rx_parity_error (rx_parity_error),
        .rx_stop_error   (rx_stop_error),
        .frame_count     (frame_count),
        .error_count     (error_count)
    );

    initial begin
        baud_clk = 1'b0;
        forever #50 baud_clk = ~baud_clk;   // 100 ns bit time
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string label, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("%s: pass", label);
        end else begin
            fail_cnt++;
            $display("%s: fail", label);
        end
    endtask

    // Start, data LSB first, parity, stop
    function automatic logic [10:0] build_frame(input link_pkg::data_t b,
                                                input int pflip, input int sflip);
        logic parity;
        logic stop;
        parity = (^b) ^ `LINK_ODD_PARITY;   // Data XOR parity equals the mode
        if (pflip != 0) begin
            parity = ~parity;
        end
        stop = (sflip != 0) ? 1'b0 : 1'b1;
        return {stop, parity, b, 1'b0};
    endfunction

    task automatic wait_rx_valid(output int cycles, output bit seen);
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge baud_clk);
            cycles++;
            seen = rx_valid;
        end
        if (!seen) begin
            $display("Timeout: rx_valid did not arrive within %0d cycles", TIMEOUT_CYCLES);
            err_cnt++;
        end
    endtask

    task automatic wait_busy_high(output bit seen);
        int cycles;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge baud_clk);
            cycles++;
            seen = tx_busy;
        end
        if (!seen) begin
            $display("Timeout: tx_busy did not rise within %0d cycles", TIMEOUT_CYCLES);
            err_cnt++;
        end
    endtask

    // Called in the cycle where rx_valid is high
    task automatic check_frame(input int idx);
        logic bad;
        check_value("rx_parity_error", exp_par_q[idx], rx_parity_error);
        check_value("rx_stop_error", exp_stop_q[idx], rx_stop_error);
        bad = (exp_par_q[idx] != 0) || (exp_stop_q[idx] != 0);
        exp_frames++;
        if (bad) begin
            exp_errors++;                   // Last good byte stays
        end else begin
            exp_last = byte_q[idx];
        end
        @(negedge baud_clk);                // Status shows one cycle later
        check_value("rx_valid", 0, rx_valid);
        check_value("rx_data", exp_last, rx_data);
        check_value("frame_count", exp_frames, frame_count);
        check_value("error_count", exp_errors, error_count);
    endtask

    task automatic run_loop(input int idx);
        int errs_before;
        int cycles;
        bit seen;
        errs_before = err_cnt;
        @(posedge baud_clk);
        loop_mode <= 1'b1;
        tx_data   <= byte_q[idx];
        tx_start  <= 1'b1;
        @(posedge baud_clk);
        tx_start  <= 1'b0;
        wait_busy_high(seen);
        if (seen) begin
            check_value("tx_line", 0, tx_line);         // Start bit on the line
            wait_rx_valid(cycles, seen);
            if (seen) begin
                check_value("rx_valid latency", FRAME_CYCLES, cycles);
                check_frame(idx);
            end
        end
        report_test($sformatf("pattern %0d LOOP %h", idx, byte_q[idx]), errs_before);
    endtask

    task automatic run_busy(input int idx);
        int errs_before;
        int busy_cycles;
        int k;
        bit seen;
        bit extra_valid;
        bit extra_busy;
        errs_before = err_cnt;
        extra_valid = 1'b0;
        extra_busy  = 1'b0;
        @(posedge baud_clk);
        loop_mode <= 1'b1;
        tx_data   <= byte_q[idx];
        tx_start  <= 1'b1;
        @(posedge baud_clk);
        tx_start  <= 1'b0;
        wait_busy_high(seen);
        if (seen) begin
            busy_cycles = 0;
            while (tx_busy && busy_cycles < TIMEOUT_CYCLES) begin
                busy_cycles++;
                @(posedge baud_clk);
                tx_start <= (busy_cycles == 2);         // Second start mid frame
                tx_data  <= ~byte_q[idx];
                @(negedge baud_clk);
            end
            if (tx_busy) begin
                $display("Timeout: tx_busy did not fall within %0d cycles", TIMEOUT_CYCLES);
                err_cnt++;
            end else begin
                check_value("tx_busy cycles", FRAME_CYCLES, busy_cycles);
                if (rx_valid) begin
                    check_frame(idx);
                end else begin
                    $display("rx_valid did not rise when the busy frame ended");
                    err_cnt++;
                end
            end
            // Ignored start must leave the line quiet
            for (k = 0; k < FRAME_CYCLES + 2; k++) begin
                @(negedge baud_clk);
                extra_valid = extra_valid | rx_valid;
                extra_busy  = extra_busy | tx_busy;
            end
            check_value("rx_valid after ignored start", 0, extra_valid);
            check_value("tx_busy after ignored start", 0, extra_busy);
            check_value("frame_count", exp_frames, frame_count);
        end
        report_test($sformatf("pattern %0d BUSY %h", idx, byte_q[idx]), errs_before);
    endtask

    // Consecutive RAW lines, no idle between frames
    task automatic drive_burst(input int first, input int last);
        logic [10:0] bits;
        int          i;
        int          k;
        for (i = first; i <= last; i++) begin
            bits = build_frame(byte_q[i], pflip_q[i], sflip_q[i]);
            for (k = 0; k < FRAME_CYCLES; k++) begin
                @(posedge baud_clk);
                raw_line <= bits[k];
            end
        end
        @(posedge baud_clk);
        raw_line <= 1'b1;                   // Idle after the last stop bit
    endtask

    task automatic check_burst(input int first, input int last);
        int i;
        int errs_before;
        int cycles;
        bit seen;
        for (i = first; i <= last; i++) begin
            errs_before = err_cnt;
            wait_rx_valid(cycles, seen);
            if (seen) begin
                check_frame(i);
            end
            report_test($sformatf("pattern %0d RAW %h", i, byte_q[i]), errs_before);
        end
    endtask

    task automatic run_burst(input int first, input int last);
        @(posedge baud_clk);
        loop_mode <= 1'b0;
        fork
            drive_burst(first, last);
            check_burst(first, last);
        join
    endtask

    task automatic load_patterns(output bit ok);
        int               fd;
        int               code;
        bit               done;
        logic [8*8-1:0]   tok;
        logic [8*128-1:0] skip;
        link_pkg::data_t  b;
        int               pf;
        int               sf;
        int               ep;
        int               es;
        ok   = 1'b0;
        done = 1'b0;
        fd   = $fopen("bench/link_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file bench/link_patterns.txt");
        end else begin
            ok = 1'b1;
            while (!done) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    done = 1'b1;            // End of file
                end else if (tok == "#") begin
                    code = $fgets(skip, fd);    // Rest of a comment line
                end else begin
                    code = $fscanf(fd, "%h %d %d %d %d", b, pf, sf, ep, es);
                    if (code != 5) begin
                        $display("Pattern line after %0d entries is incomplete", op_q.size());
                        err_cnt++;
                        done = 1'b1;
                    end else if (tok == "LOOP" || tok == "RAW" || tok == "BUSY") begin
                        op_q.push_back(tok == "LOOP" ? OP_LOOP :
                                       (tok == "RAW" ? OP_RAW : OP_BUSY));
                        byte_q.push_back(b);
                        pflip_q.push_back(pf);
                        sflip_q.push_back(sf);
                        exp_par_q.push_back(ep);
                        exp_stop_q.push_back(es);
                    end else begin
                        $display("Pattern file holds an unknown operation");
                        err_cnt++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin : main_flow
        int gap;
        int i;
        int last;
        int errs_before;
        bit loaded;
        err_cnt    = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        exp_frames = 0;
        exp_errors = 0;
        exp_last   = '0;
        reset     <= 1'b1;
        tx_data   <= '0;
        tx_start  <= 1'b0;
        raw_line  <= 1'b1;                  // Idle line level
        loop_mode <= 1'b0;
        rng_seed = 32'hbb26027f;
        gap = $urandom(rng_seed);           // Seeds the generator once
        load_patterns(loaded);
        repeat (10) @(posedge baud_clk);
        reset <= 1'b0;
        @(negedge baud_clk);

        errs_before = err_cnt;
        check_value("tx_line", 1, tx_line);
        check_value("tx_busy", 0, tx_busy);
        check_value("rx_valid", 0, rx_valid);
        check_value("rx_parity_error", 0, rx_parity_error);
        check_value("rx_stop_error", 0, rx_stop_error);
        check_value("frame_count", 0, frame_count);
        check_value("error_count", 0, error_count);
        check_value("rx_data", 0, rx_data);
        report_test("reset values", errs_before);

        if (!loaded || op_q.size() == 0) begin
            $display("No tests could be read from the pattern file");
            err_cnt++;
        end else begin
            i = 0;
            while (i < op_q.size()) begin
                gap = $urandom % 4;         // Idle cycles before the next test
                repeat (gap) @(posedge baud_clk);
                if (op_q[i] == OP_LOOP) begin
                    run_loop(i);
                    i++;
                end else if (op_q[i] == OP_BUSY) begin
                    run_busy(i);
                    i++;
                end else begin
                    last = i;
                    while (last + 1 < op_q.size() && op_q[last + 1] == OP_RAW) begin
                        last++;
                    end
                    run_burst(i, last);
                    i = last + 1;
                end
            end
        end

        $display("Closing counts: %0d passed, %0d failed, %0d check errors",
                 pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- bench/link_patterns.txt
# op byte parity_flip stop_flip exp_parity_err exp_stop_err
# LOOP goes through tx_start, RAW drives rx_line, BUSY retries start while busy
# Consecutive RAW lines go out back to back
LOOP 55 0 0 0 0
LOOP aa 0 0 0 0
LOOP 00 0 0 0 0
LOOP ff 0 0 0 0
LOOP 01 0 0 0 0
LOOP 80 0 0 0 0
RAW  3c 0 0 0 0
RAW  a5 1 0 1 0
RAW  5a 0 1 0 1
RAW  c3 1 1 1 1
RAW  7e 0 0 0 0
BUSY 96 0 0 0 0
LOOP 69 0 0 0 0
RAW  12 1 0 1 0
LOOP 34 0 0 0 0
RAW  de 0 0 0 0
RAW  ad 0 0 0 0
RAW  be 0 1 0 1
RAW  ef 0 0 0 0
RAW  00 1 0 1 0
RAW  ff 0 0 0 0
BUSY 0f 0 0 0 0
BUSY f0 0 0 0 0
LOOP 5c 0 0 0 0
RAW  01 0 1 0 1
RAW  02 0 1 0 1
RAW  04 0 0 0 0
LOOP 08 0 0 0 0
RAW  10 1 1 1 1
BUSY 20 0 0 0 0
LOOP 40 0 0 0 0
RAW  e7 0 0 0 0
RAW  18 1 0 1 0
RAW  24 0 0 0 0
LOOP c8 0 0 0 0
LOOP 7f 0 0 0 0
BUSY b1 0 0 0 0

//--- files.f
+incdir+verilog
verilog/link_pkg.sv
verilog/rx_frame_if.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/rx_status.sv
verilog/serial_link_top.sv
bench/serial_link_tb.sv
